/* filelist.f */
noc_pkg.sv
noc_input_fifo.sv
noc_route_calc.sv
noc_switch_control.sv
noc_crossbar.sv
noc_router.sv
tb_clock_gen.sv
tb_noc_router.sv

/* Makefile */
# Verilator build and run for the five-port mesh router

VERILATOR  ?= verilator
TOP        ?= tb_noc_router
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_LINE  ?= Simulation PASSED
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_LINE)" $(LOG) || { echo "pass line missing in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_noc_router.sv */
// Testbench for the five-port mesh router
// Directed routing table, contention and back-pressure phases, then random
// traffic. A scoreboard keeps expected packets per source and output and
// checks every delivered word against the XY rule and per-source order

module tb_noc_router;

  localparam int NP          = noc_pkg::NUM_PORTS;
  localparam int X_LOC       = 1;    // Router column under test
  localparam int Y_LOC       = 2;    // Router row under test
  localparam int N_ROUTE     = 7;    // Routing table entries
  localparam int N_RANDOM    = 400;  // Random traffic cycles
  localparam int DRAIN_LIMIT = 200;  // Cycles allowed for any drain wait

  // One directed routing case
  typedef struct packed {
    logic [2:0]         src;      // Input port
    noc_pkg::coord_t    dest_x;
    noc_pkg::coord_t    dest_y;
    noc_pkg::payload_t  payload;  // Top 3 bits hold the source port
    noc_pkg::port_vec_t en;       // Downstream enables for this case
    logic [2:0]         exp_out;  // Output the packet must leave on
  } route_entry_t;

  logic clk;
  logic reset_n;

  noc_pkg::packet_t   [NP-1:0] i_data;
  noc_pkg::port_vec_t          i_data_val;
  noc_pkg::port_vec_t          o_en;
  noc_pkg::packet_t   [NP-1:0] o_data;
  noc_pkg::port_vec_t          o_data_val;
  noc_pkg::port_vec_t          i_en;

  noc_pkg::packet_t   [NP-1:0] drv_data;   // Packets offered next cycle
  noc_pkg::packet_t   [NP-1:0] last_data;  // Outputs seen in the last cycle
  noc_pkg::port_vec_t          last_val;

  noc_pkg::packet_t exp_q [NP*NP][$];      // Expected packets, [src*NP + out]
  logic [12:0]      seq [NP];              // Next sequence number per source
  logic [31:0]      rng;                   // Xorshift state
  int               written;
  int               delivered;
  int               err_count;

  // Other outputs are masked off by en to show they do not matter
  route_entry_t route_tbl [N_ROUTE] = '{
    '{3'd0, 2'd1, 2'd2, 16'h0a11, 5'h1f, 3'd0},   // Local to local
    '{3'd0, 2'd3, 2'd2, 16'h0b12, 5'h16, 3'd2},   // Local to east
    '{3'd2, 2'd0, 2'd3, 16'h4b22, 5'h1f, 3'd4},   // X smaller wins over y
    '{3'd1, 2'd1, 2'd3, 16'h2c33, 5'h0f, 3'd3},   // Same column, south
    '{3'd3, 2'd1, 2'd0, 16'h6d44, 5'h1f, 3'd1},   // Same column, north
    '{3'd4, 2'd2, 2'd0, 16'h8e55, 5'h05, 3'd2},   // X first, east
    '{3'd1, 2'd1, 2'd2, 16'h2f66, 5'h01, 3'd0}    // North in, arrived
  };

  tb_clock_gen u_clk_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  noc_router #(
    .X_LOC (X_LOC),
    .Y_LOC (Y_LOC)
  ) uut (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  // ----------------------------------------------------------------------
  // Reference models and helpers
  // ----------------------------------------------------------------------
  function automatic int route_ref(input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
    if (int'(dx) > X_LOC) return noc_pkg::PORT_EAST;
    if (int'(dx) < X_LOC) return noc_pkg::PORT_WEST;
    if (int'(dy) > Y_LOC) return noc_pkg::PORT_SOUTH;  // South is larger y
    if (int'(dy) < Y_LOC) return noc_pkg::PORT_NORTH;
    return noc_pkg::PORT_LOCAL;
  endfunction

  // First requester at or after ptr, cyclic
  function automatic int rr_pick(input noc_pkg::port_vec_t req, input int ptr);
    int idx;
    for (int k = 0; k < NP; k++) begin
      idx = (ptr + k) % NP;
      if (req[idx]) return idx;
    end
    return -1;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic noc_pkg::packet_t make_packet(input int src, input int dx, input int dy);
    noc_pkg::packet_t pkt;
    pkt.dest_x  = noc_pkg::coord_t'(dx);
    pkt.dest_y  = noc_pkg::coord_t'(dy);
    pkt.payload = {3'(src), seq[src]};  // Source tag and sequence number
    return pkt;
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int i = 0; i < NP*NP; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  task automatic stop_on_error(input string what);
    err_count++;
    $display("error: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("%s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Compare every valid output with the front of its source queue
  task automatic sample_outputs();
    int src;
    noc_pkg::packet_t exp_pkt;
    check_value("o_data_val & ~i_en", o_data_val & ~i_en, '0);
    for (int o = 0; o < NP; o++) begin
      if (o_data_val[o]) begin
        src = int'(o_data[o].payload[15:13]);
        if (src >= NP) begin
          stop_on_error($sformatf("unknown source tag on output %0d", o));
        end else if (exp_q[src*NP + o].size() == 0) begin
          stop_on_error($sformatf("unexpected packet on output %0d from %0d", o, src));
        end else begin
          exp_pkt = exp_q[src*NP + o].pop_front();
          check_value($sformatf("o_data[%0d]", o), o_data[o], exp_pkt);
          delivered++;
        end
      end
    end
    last_val  = o_data_val;
    last_data = o_data;
  endtask

  // One clock cycle. Drive at the falling edge, sample once inputs settled
  task automatic apply_cycle(input noc_pkg::port_vec_t val_req,
                             input noc_pkg::port_vec_t en, input logic respect_room);
    noc_pkg::port_vec_t val;
    int out;
    @(negedge clk);
    val        = respect_room ? (val_req & o_en) : val_req;  // Upstream honours o_en
    i_data     = drv_data;
    i_data_val = val;
    i_en       = en;
    #1;
    for (int p = 0; p < NP; p++) begin
      if (val[p]) begin
        check_value($sformatf("o_en[%0d]", p), o_en[p], 1'b1);
        out = route_ref(drv_data[p].dest_x, drv_data[p].dest_y);
        exp_q[p*NP + out].push_back(drv_data[p]);
        seq[p] = seq[p] + 1'b1;
        written++;
      end
    end
    sample_outputs();
  endtask

  // ----------------------------------------------------------------------
  // Test phases
  // ----------------------------------------------------------------------
  // Rounds on the east output, pointer model starts at input 0
  task automatic run_contention();
    noc_pkg::port_vec_t rounds [3];
    noc_pkg::port_vec_t left;
    int ref_ptr;
    int win;
    int n_pkt;
    rounds  = '{5'b10001, 5'b01011, 5'b10001};
    ref_ptr = 0;
    for (int r = 0; r < 3; r++) begin
      for (int p = 0; p < NP; p++) begin
        drv_data[p] = make_packet(p, 3, 2);   // All head east
      end
      apply_cycle(rounds[r], '1, 1'b0);
      left  = rounds[r];
      n_pkt = $countones(left);
      for (int n = 0; n < n_pkt; n++) begin   // Winners on consecutive cycles
        apply_cycle('0, '1, 1'b0);
        win = rr_pick(left, ref_ptr);
        check_value("o_data_val", last_val, 5'b1 << noc_pkg::PORT_EAST);
        check_value("o_data[east] source", last_data[noc_pkg::PORT_EAST].payload[15:13], win);
        left[win] = 1'b0;
        ref_ptr   = (win + 1) % NP;
      end
    end
  endtask

  task automatic run_routing();
    route_entry_t e;
    for (int n = 0; n < N_ROUTE; n++) begin
      e = route_tbl[n];
      check_value("exp_out", e.exp_out, route_ref(e.dest_x, e.dest_y));
      drv_data                 = '0;
      drv_data[e.src].dest_x  = e.dest_x;
      drv_data[e.src].dest_y  = e.dest_y;
      drv_data[e.src].payload = e.payload;
      apply_cycle(noc_pkg::port_vec_t'(1 << e.src), e.en, 1'b0);
      check_value("o_data_val", last_val, '0);       // Not out in its write cycle
      apply_cycle('0, e.en, 1'b0);
      check_value("o_data_val", last_val, noc_pkg::port_vec_t'(1 << e.exp_out));
      check_value("o_data", last_data[e.exp_out], drv_data[e.src]);
    end
  endtask

  // Fill the north queue towards a blocked south output, then release
  task automatic run_backpressure();
    noc_pkg::port_vec_t hold_en;
    int got;
    int cyc;
    hold_en                      = '1;
    hold_en[noc_pkg::PORT_SOUTH] = 1'b0;
    for (int n = 0; n < noc_pkg::FIFO_DEPTH; n++) begin
      drv_data[noc_pkg::PORT_NORTH] = make_packet(noc_pkg::PORT_NORTH, 1, 3);
      apply_cycle(5'b1 << noc_pkg::PORT_NORTH, hold_en, 1'b0);
      check_value("o_data_val[south]", last_val[noc_pkg::PORT_SOUTH], 1'b0);
    end
    apply_cycle('0, hold_en, 1'b0);
    check_value("o_data_val[south]", last_val[noc_pkg::PORT_SOUTH], 1'b0);
    check_value("o_en[north]", o_en[noc_pkg::PORT_NORTH], 1'b0);   // Queue full
    got = 0;
    cyc = 0;
    while (got < noc_pkg::FIFO_DEPTH && cyc < DRAIN_LIMIT) begin
      apply_cycle('0, '1, 1'b0);
      if (last_val[noc_pkg::PORT_SOUTH]) got++;
      cyc++;
    end
    if (got < noc_pkg::FIFO_DEPTH) begin
      stop_on_error("timeout waiting for the held packets on the south output");
    end
    check_value("o_en[north]", o_en[noc_pkg::PORT_NORTH], 1'b1);
  endtask

  task automatic run_random();
    noc_pkg::port_vec_t val_req;
    noc_pkg::port_vec_t en;
    int cyc;
    for (int n = 0; n < N_RANDOM; n++) begin
      rng     = xorshift32(rng);
      val_req = rng[4:0];
      en      = rng[9:5] | rng[14:10];   // Mostly enabled outputs
      for (int p = 0; p < NP; p++) begin
        rng         = xorshift32(rng);
        drv_data[p] = make_packet(p, int'(rng[1:0]), int'(rng[3:2]));
      end
      apply_cycle(val_req, en, 1'b1);
    end
    cyc = 0;
    while ((pending() != 0 || o_en != '1) && cyc < DRAIN_LIMIT) begin
      apply_cycle('0, '1, 1'b0);
      cyc++;
    end
    if (pending() != 0) begin
      stop_on_error("timeout waiting for the input queues to drain");
    end
    check_value("delivered", delivered, written);
    check_value("o_en", o_en, 5'h1f);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int cyc;
    i_data     = '0;
    i_data_val = '0;
    i_en       = '1;
    drv_data   = '0;
    last_data  = '0;
    last_val   = '0;
    rng        = 32'hc5ec;
    written    = 0;
    delivered  = 0;
    err_count  = 0;
    for (int p = 0; p < NP; p++) begin
      seq[p] = '0;
    end

    cyc = 0;
    while (reset_n !== 1'b1 && cyc < 100) begin
      @(negedge clk);
      cyc++;
    end
    if (reset_n !== 1'b1) begin
      stop_on_error("timeout waiting for reset release");
    end

    apply_cycle('0, '1, 1'b0);                 // Idle state after reset
    check_value("o_data_val", last_val, '0);
    check_value("o_en", o_en, 5'h1f);

    run_contention();                           // Needs pointers fresh from reset
    run_routing();
    run_backpressure();
    run_random();

    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source
// Free-running clock with a period of 20, active-low reset held 10 cycles

module tb_clock_gen (
  output logic o_clk,      // Testbench clock
  output logic o_reset_n   // Synchronous reset, active low
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;      // Half period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (10) @(posedge o_clk);
    @(negedge o_clk);                // Release away from the sampling edge
    o_reset_n = 1'b1;
  end

endmodule

/* noc_router.sv */
// Input-buffered mesh router, five ports
// Local, north, east, south and west inputs each feed a packet queue
// XY route calculation on every queue head, round-robin switch control
// and a one-hot crossbar towards the outputs
// Simple level flow control, o_en upstream and i_en downstream

module noc_router #(
  parameter int X_LOC = 0,  // Router column in the mesh
  parameter int Y_LOC = 0   // Router row in the mesh
) (
  input  logic                                        clk,
  input  logic                                        reset_n,

  // ----------------------------------------------------------------------
  // Upstream side, [local, north, east, south, west]
  // ----------------------------------------------------------------------
  input  noc_pkg::packet_t   [noc_pkg::NUM_PORTS-1:0] i_data,      // Packets in
  input  noc_pkg::port_vec_t                          i_data_val,  // Write per input
  output noc_pkg::port_vec_t                          o_en,        // Queue has room

  // ----------------------------------------------------------------------
  // Downstream side
  // ----------------------------------------------------------------------
  output noc_pkg::packet_t   [noc_pkg::NUM_PORTS-1:0] o_data,      // Packets out
  output noc_pkg::port_vec_t                          o_data_val,  // Valid per output
  input  noc_pkg::port_vec_t                          i_en         // Neighbour can take a word
);

  noc_pkg::packet_t   [noc_pkg::NUM_PORTS-1:0] head;      // Queue heads, [input]
  noc_pkg::port_vec_t                          head_val;  // Head valid per input
  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] req;       // Route requests, [input]
  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] grant;     // Grants, [output]
  noc_pkg::port_vec_t                          rd;        // Pop strobe per input

  // Queue and route calculator per input port
  for (genvar g = 0; g < noc_pkg::NUM_PORTS; g++) begin : g_input
    noc_input_fifo u_fifo (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[g]),      // From upstream
      .i_data_val (i_data_val[g]),
      .i_rd       (rd[g]),          // From switch control
      .o_data     (head[g]),        // To crossbar and route calc
      .o_data_val (head_val[g]),
      .o_en       (o_en[g])         // To upstream
    );

    noc_route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) u_route (
      .i_dest_x (head[g].dest_x),
      .i_dest_y (head[g].dest_y),
      .i_val    (head_val[g]),
      .o_req    (req[g])            // To switch control
    );
  end

  // Arbitration per output, grants come back transposed
  noc_switch_control u_switch_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .i_req   (req),
    .i_en    (i_en),                // Downstream back-pressure
    .o_grant (grant),
    .o_rd    (rd)
  );

  noc_crossbar u_xbar (
    .i_sel      (grant),
    .i_data     (head),
    .o_data     (o_data),
    .o_data_val (o_data_val)
  );

endmodule

/* noc_crossbar.sv */
// One-hot crossbar
// Each output selects at most one input queue head through a one-hot
// select, and the output is valid whenever a select bit is set

module noc_crossbar (
  input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] i_sel,      // [output], bit per input
  input  noc_pkg::packet_t   [noc_pkg::NUM_PORTS-1:0] i_data,     // Queue heads, [input]
  output noc_pkg::packet_t   [noc_pkg::NUM_PORTS-1:0] o_data,     // [output]
  output noc_pkg::port_vec_t                          o_data_val  // Output carries a packet
);

  always_comb begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      o_data[o] = '0;                          // Idle outputs drive zero
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (i_sel[o][i]) begin
          o_data[o] = i_data[i];
        end
      end
      o_data_val[o] = |i_sel[o];               // Any grant means valid
    end
  end

endmodule

/* noc_switch_control.sv */
// Switch control
// One round-robin arbiter per output port, gated by the downstream
// enable of that output, producing one-hot grants over the inputs
// and the per-input read strobes for the input queues

module noc_switch_control (
  input  logic                                        clk,
  input  logic                                        reset_n,
  input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] i_req,    // [input], bit per output
  input  noc_pkg::port_vec_t                          i_en,     // Downstream ready per output
  output noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] o_grant,  // [output], bit per input
  output noc_pkg::port_vec_t                          o_rd      // Pop strobe per input
);

  // Priority pointer and winner per output
  logic [$clog2(noc_pkg::NUM_PORTS)-1:0] ptr_q   [noc_pkg::NUM_PORTS];
  logic [$clog2(noc_pkg::NUM_PORTS)-1:0] win_idx [noc_pkg::NUM_PORTS];

  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] grant_col;  // Grants transposed to [input]

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  // Scan candidates from farthest to nearest in cyclic order so that the
  // last hit, the one closest to the pointer, is the one that remains
  always_comb begin
    int idx;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      o_grant[o] = '0;
      win_idx[o] = '0;
      for (int k = noc_pkg::NUM_PORTS-1; k >= 0; k--) begin
        idx = int'(ptr_q[o]) + k;
        if (idx >= noc_pkg::NUM_PORTS) begin
          idx = idx - noc_pkg::NUM_PORTS;   // Cyclic wrap
        end
        if (i_en[o] && i_req[idx][o]) begin
          o_grant[o]      = '0;
          o_grant[o][idx] = 1'b1;
          win_idx[o]      = idx[$clog2(noc_pkg::NUM_PORTS)-1:0];
        end
      end
    end
  end

  // An input pops when any output took it
  always_comb begin
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        grant_col[i][o] = o_grant[o][i];
      end
    end
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      o_rd[i] = |grant_col[i];
    end
  end

  // ----------------------------------------------------------------------
  // Priority pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        ptr_q[o] <= '0;                      // Input 0 first after reset
      end
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        if (|o_grant[o]) begin               // Idle or blocked output keeps its pointer
          ptr_q[o] <= (win_idx[o] == noc_pkg::NUM_PORTS-1) ? '0 : win_idx[o] + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < noc_pkg::NUM_PORTS; g++) begin : g_chk
    // Holds only while each route calculator raises a single request
    a_single_output: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(grant_col[g]))
      else $error("noc_switch_control: input %0d granted twice", g);
  end

endmodule

/* noc_route_calc.sv */
// XY route calculation
// Turns the destination of a head packet into a one-hot output request
// X is resolved first, then Y, then the packet goes to the local core

module noc_route_calc #(
  parameter int X_LOC = 0,  // Own column
  parameter int Y_LOC = 0   // Own row, y grows to the south
) (
  input  noc_pkg::coord_t    i_dest_x,  // Destination column of head
  input  noc_pkg::coord_t    i_dest_y,  // Destination row of head
  input  logic               i_val,     // Head is valid
  output noc_pkg::port_vec_t o_req      // One bit per output port
);

  always_comb begin
    o_req = '0;
    if (i_val) begin
      // Dimension order, x first
      if (i_dest_x > noc_pkg::coord_t'(X_LOC)) begin
        o_req[noc_pkg::PORT_EAST] = 1'b1;
      end else if (i_dest_x < noc_pkg::coord_t'(X_LOC)) begin
        o_req[noc_pkg::PORT_WEST] = 1'b1;
      end else if (i_dest_y > noc_pkg::coord_t'(Y_LOC)) begin
        o_req[noc_pkg::PORT_SOUTH] = 1'b1;   // Larger y lies south
      end else if (i_dest_y < noc_pkg::coord_t'(Y_LOC)) begin
        o_req[noc_pkg::PORT_NORTH] = 1'b1;
      end else begin
        o_req[noc_pkg::PORT_LOCAL] = 1'b1;   // Arrived
      end
    end
  end

endmodule

/* noc_input_fifo.sv */
// Input queue for one router port
// Circular buffer of packets with an occupancy counter
// o_en tells upstream there is room, o_data_val flags a valid head

module noc_input_fifo (
  input  logic             clk,
  input  logic             reset_n,
  input  noc_pkg::packet_t i_data,      // Packet from upstream
  input  logic             i_data_val,  // Write request, only while o_en high
  input  logic             i_rd,        // Pop head, from switch control
  output noc_pkg::packet_t o_data,      // Head packet
  output logic             o_data_val,  // Head is valid
  output logic             o_en         // Room for at least one packet
);

  noc_pkg::packet_t mem [noc_pkg::FIFO_DEPTH];        // Packet storage

  logic [$clog2(noc_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;  // Next slot to write
  logic [$clog2(noc_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;  // Current head slot
  noc_pkg::count_t                        count_q;   // Stored packets

  logic wr;  // Accepted write
  logic rd;  // Accepted read

  // ----------------------------------------------------------------------
  // Flow control levels
  // ----------------------------------------------------------------------
  assign o_en       = (count_q < noc_pkg::count_t'(noc_pkg::FIFO_DEPTH));
  assign o_data_val = (count_q != '0);

  assign wr = i_data_val & o_en;      // Push only with room
  assign rd = i_rd & o_data_val;

  assign o_data = mem[rd_ptr_q];      // Head visible the cycle after its write

  // Packet storage written on an accepted push
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr) begin
        // Wrap explicitly so any depth works
        wr_ptr_q <= (wr_ptr_q == noc_pkg::FIFO_DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::FIFO_DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr, rd})
        2'b10:   count_q <= count_q + 1'b1;  // Push only
        2'b01:   count_q <= count_q - 1'b1;  // Pop only
        default: count_q <= count_q;         // Idle or push and pop together
      endcase
    end
  end

  // Upstream respects o_en
  a_no_write_full: assert property (@(posedge clk) disable iff (!reset_n)
    i_data_val |-> o_en)
    else $error("noc_input_fifo: write while full");

  // Switch control pops only a valid head
  a_no_read_empty: assert property (@(posedge clk) disable iff (!reset_n)
    i_rd |-> o_data_val)
    else $error("noc_input_fifo: read while empty");

endmodule

/* noc_pkg.sv */
// NoC router package
// Mesh geometry, port numbering, input queue depth and the packet
// format shared by all blocks of the five-port input-buffered router

package noc_pkg;

  // ----------------------------------------------------------------------
  // Router ports
  // ----------------------------------------------------------------------
  localparam int NUM_PORTS  = 5;  // Local core plus four neighbours

  localparam int PORT_LOCAL = 0;  // Attached processing core
  localparam int PORT_NORTH = 1;  // Towards smaller y
  localparam int PORT_EAST  = 2;  // Towards larger x
  localparam int PORT_SOUTH = 3;  // Towards larger y
  localparam int PORT_WEST  = 4;  // Towards smaller x

  // ----------------------------------------------------------------------
  // Mesh and buffering
  // ----------------------------------------------------------------------
  localparam int MESH_X     = 4;  // Columns
  localparam int MESH_Y     = 4;  // Rows
  localparam int FIFO_DEPTH = 4;  // Packets per input queue

  // One coordinate, sized for the larger mesh dimension
  typedef logic [$clog2((MESH_X > MESH_Y) ? MESH_X : MESH_Y)-1:0] coord_t;

  typedef logic [15:0] payload_t;  // Packet data

  // One bit per router port, bit index equals port index
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // Queue occupancy, must reach FIFO_DEPTH itself
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] count_t;

  // Single-flit packet, destination first
  typedef struct packed {
    coord_t   dest_x;   // Destination column
    coord_t   dest_y;   // Destination row
    payload_t payload;  // Carried data
  } packet_t;

endpackage
